//--- source/conv_router_pkg.sv
package conv_router_pkg;

    //////////////////////////////////////////////////
    // dimensions and limits
    //////////////////////////////////////////////////

    // every dimension, row index and address
    localparam int DIM_W = 16;
    typedef logic [DIM_W-1:0] dim_t;

    // output rows per tile, one lane each
    localparam int LANES = 3;

    // round-robin row buffers
    localparam int NUM_ROW_BUFS = 3;
    typedef logic [1:0] bank_t;

    // one row segment is 32 pixels
    localparam int PIXELS_IN_ROW = 32;
    localparam int PIXELS_LOG2 = 5;

    // marks a lane without a row
    localparam dim_t NO_ROW = '1;

    // config field widths, k/s/p and the log2 sizes
    localparam int KSP_W = 2;
    localparam int LOG2_W = 3;

    //////////////////////////////////////////////////
    // beat structures
    //////////////////////////////////////////////////

    // one loop position from the controller
    typedef struct packed {
        dim_t       oy_start;
        logic [1:0] poy;
        logic [1:0] kr;
        dim_t       seg_start;
        dim_t       if_idx;
        logic       last;
    } loop_pos_t;

    // result of one row lane
    typedef struct packed {
        logic  used;
        logic  pad;
        dim_t  row_idx;
        bank_t buf_idx;
        dim_t  buf_adr;
    } lane_beat_t;

    // output payload, lane 0 in the low slot
    typedef struct packed {
        lane_beat_t [LANES-1:0] lane;
        dim_t                   seg_start;
        dim_t                   if_idx;
        logic                   last;
    } beat_t;

endpackage

//--- source/layer_cfg_if.sv
`timescale 1ns/1ps

interface layer_cfg_if;

    // output and input rows
    conv_router_pkg::dim_t oy;
    conv_router_pkg::dim_t iy;

    // kernel rows, stride, top/bottom padding
    logic [conv_router_pkg::KSP_W-1:0] k;
    logic [conv_router_pkg::KSP_W-1:0] s;
    logic [conv_router_pkg::KSP_W-1:0] p;

    // row width and channel count as log2
    logic [conv_router_pkg::LOG2_W-1:0] ix_log2;
    logic [conv_router_pkg::LOG2_W-1:0] nif_log2;

    // loop controller side
    modport ctrl (
        input oy, k, ix_log2, nif_log2
    );

    // row lane side
    modport lane (
        input iy, s, p, ix_log2, nif_log2
    );

endinterface

//--- source/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    //////////////////////////////////////////////////
    // one-entry register slice
    //////////////////////////////////////////////////

    // free when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;

    // valid flag
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload, loaded on accept only
    // held while the consumer stalls
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

//--- source/conv_row_lane.sv
`timescale 1ns/1ps

module conv_row_lane #(
    parameter int LANE = 0
) (
    layer_cfg_if.lane                   cfg,
    input  conv_router_pkg::loop_pos_t  pos,
    output conv_router_pkg::lane_beat_t beat
);

    // wide enough for scaled row plus sign
    localparam int YW = conv_router_pkg::DIM_W + 3;

    logic [YW-1:0]         out_row;
    logic [YW-1:0]         scaled_row;
    logic [YW-1:0]         y_ext;
    logic                  used;
    logic                  pad;
    conv_router_pkg::dim_t y;
    conv_router_pkg::dim_t y_quot;
    logic [3:0]            row_shift;
    conv_router_pkg::dim_t row_term;
    conv_router_pkg::dim_t seg_term;

    //////////////////////////////////////////////////
    // input row of this lane
    //////////////////////////////////////////////////

    assign used       = (LANE < int'(pos.poy));
    assign out_row    = YW'(pos.oy_start) + YW'(LANE);
    assign scaled_row = out_row * YW'(cfg.s);
    // kernel row offset minus top padding
    assign y_ext      = scaled_row + YW'(pos.kr) - YW'(cfg.p);
    assign y          = y_ext[conv_router_pkg::DIM_W-1:0];

    // negative wraps to msb set, else check bottom edge
    assign pad = used && (y_ext[YW-1] || (y_ext >= YW'(cfg.iy)));

    //////////////////////////////////////////////////
    // bank split and word address
    //////////////////////////////////////////////////

    // row within its bank
    assign y_quot    = y / conv_router_pkg::dim_t'(conv_router_pkg::NUM_ROW_BUFS);
    // words per stored row
    assign row_shift = 4'(cfg.nif_log2) + 4'(cfg.ix_log2) - 4'(conv_router_pkg::PIXELS_LOG2);
    assign row_term  = y_quot << row_shift;
    // segment offset in channel-interleaved words
    assign seg_term  = (pos.seg_start << cfg.nif_log2) >> conv_router_pkg::PIXELS_LOG2;

    always_comb begin
        beat.used = used;
        beat.pad  = pad;
        if (used && !pad) begin
            beat.row_idx = y;
            beat.buf_idx = conv_router_pkg::bank_t'(
                y % conv_router_pkg::dim_t'(conv_router_pkg::NUM_ROW_BUFS));
            beat.buf_adr = row_term + seg_term + pos.if_idx;
        end else begin
            beat.row_idx = conv_router_pkg::NO_ROW;
            beat.buf_idx = '0;
            beat.buf_adr = conv_router_pkg::NO_ROW;
        end
    end

endmodule

//--- source/conv_loop_ctrl.sv
`timescale 1ns/1ps

module conv_loop_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    layer_cfg_if.ctrl                  cfg,
    input  logic                       pos_ready,
    input  logic                       last_taken,
    output logic                       pos_valid,
    output conv_router_pkg::loop_pos_t pos,
    output logic                       busy,
    output logic                       done
);

    // loop counters, tile outermost
    conv_router_pkg::dim_t oy_start;
    logic [1:0]            kr;
    conv_router_pkg::dim_t seg_start;
    conv_router_pkg::dim_t if_idx;

    // loop limits from the layer config
    conv_router_pkg::dim_t rows_left;
    conv_router_pkg::dim_t if_max;
    conv_router_pkg::dim_t seg_max;
    logic [1:0]            poy;

    logic if_wrap;
    logic seg_wrap;
    logic kr_wrap;
    logic tile_final;
    logic pos_last;
    logic pos_take;
    logic start_ok;

    //////////////////////////////////////////////////
    // limits and wrap detection
    //////////////////////////////////////////////////

    assign rows_left = cfg.oy - oy_start;
    // channel count is 2^nif_log2
    assign if_max = (conv_router_pkg::dim_t'(1) << cfg.nif_log2) - 1'b1;
    // start pixel of the final segment
    assign seg_max = (conv_router_pkg::dim_t'(1) << cfg.ix_log2)
                   - conv_router_pkg::dim_t'(conv_router_pkg::PIXELS_IN_ROW);

    assign if_wrap    = (if_idx == if_max);
    assign seg_wrap   = (seg_start == seg_max);
    assign kr_wrap    = (kr == cfg.k - 2'd1);
    assign tile_final = (rows_left <= conv_router_pkg::dim_t'(conv_router_pkg::LANES));
    assign pos_last   = if_wrap && seg_wrap && kr_wrap && tile_final;

    // partial tile at the bottom
    assign poy = tile_final ? rows_left[1:0] : 2'(conv_router_pkg::LANES);

    assign pos_take = pos_valid && pos_ready;
    assign start_ok = start && !busy;

    // position out, counters only move on a transfer
    assign pos.oy_start  = oy_start;
    assign pos.poy       = poy;
    assign pos.kr        = kr;
    assign pos.seg_start = seg_start;
    assign pos.if_idx    = if_idx;
    assign pos.last      = pos_last;

    //////////////////////////////////////////////////
    // run control
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start_ok) begin
                busy <= 1'b1;
            end else if (busy && last_taken) begin
                // final beat left the pipe
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // nested counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            pos_valid <= 1'b0;
            oy_start  <= '0;
            kr        <= '0;
            seg_start <= '0;
            if_idx    <= '0;
        end else if (start_ok) begin
            pos_valid <= 1'b1;
            oy_start  <= '0;
            kr        <= '0;
            seg_start <= '0;
            if_idx    <= '0;
        end else if (pos_take) begin
            if (pos_last) begin
                // nothing more to offer
                pos_valid <= 1'b0;
            end else if (!if_wrap) begin
                if_idx <= if_idx + 1'b1;
            end else begin
                if_idx <= '0;
                if (!seg_wrap) begin
                    seg_start <= seg_start
                               + conv_router_pkg::dim_t'(conv_router_pkg::PIXELS_IN_ROW);
                end else begin
                    seg_start <= '0;
                    if (!kr_wrap) begin
                        kr <= kr + 2'd1;
                    end else begin
                        // next tile of output rows
                        kr       <= '0;
                        oy_start <= oy_start
                                  + conv_router_pkg::dim_t'(conv_router_pkg::LANES);
                    end
                end
            end
        end
    end

endmodule

//--- source/conv_router.sv
`timescale 1ns/1ps

module conv_router (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                start,
    input  conv_router_pkg::dim_t                               oy,
    input  conv_router_pkg::dim_t                               iy,
    input  logic [conv_router_pkg::KSP_W-1:0]                   k,
    input  logic [conv_router_pkg::KSP_W-1:0]                   s,
    input  logic [conv_router_pkg::KSP_W-1:0]                   p,
    input  logic [conv_router_pkg::LOG2_W-1:0]                  ix_log2,
    input  logic [conv_router_pkg::LOG2_W-1:0]                  nif_log2,
    input  logic                                                out_ready,
    output logic                                                busy,
    output logic                                                done,
    output logic                                                out_valid,
    output logic                                                out_last,
    output conv_router_pkg::dim_t                               out_seg_start,
    output conv_router_pkg::dim_t                               out_if_idx,
    output logic [conv_router_pkg::LANES-1:0]                   lane_used,
    output logic [conv_router_pkg::LANES-1:0]                   lane_pad,
    output conv_router_pkg::dim_t [conv_router_pkg::LANES-1:0]  row_idx,
    output conv_router_pkg::dim_t [conv_router_pkg::LANES-1:0]  buf_adr,
    output conv_router_pkg::bank_t [conv_router_pkg::LANES-1:0] buf_idx
);

    // controller to stage_pos
    logic                       ctrl_valid;
    logic                       ctrl_ready;
    conv_router_pkg::loop_pos_t ctrl_pos;

    // stage_pos to lanes and stage_beat
    logic                       pos_valid;
    logic                       pos_ready;
    conv_router_pkg::loop_pos_t cur_pos;

    conv_router_pkg::lane_beat_t [conv_router_pkg::LANES-1:0] lane_res;
    conv_router_pkg::beat_t                                   beat_in;
    conv_router_pkg::beat_t                                   beat_out;

    logic last_taken;

    //////////////////////////////////////////////////
    // layer config
    //////////////////////////////////////////////////

    layer_cfg_if cfg_if ();

    assign cfg_if.oy       = oy;
    assign cfg_if.iy       = iy;
    assign cfg_if.k        = k;
    assign cfg_if.s        = s;
    assign cfg_if.p        = p;
    assign cfg_if.ix_log2  = ix_log2;
    assign cfg_if.nif_log2 = nif_log2;

    //////////////////////////////////////////////////
    // controller and pipeline
    //////////////////////////////////////////////////

    // final beat accepted downstream
    assign last_taken = out_valid && out_ready && beat_out.last;

    conv_loop_ctrl loop_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cfg        (cfg_if.ctrl),
        .pos_ready  (ctrl_ready),
        .last_taken (last_taken),
        .pos_valid  (ctrl_valid),
        .pos        (ctrl_pos),
        .busy       (busy),
        .done       (done)
    );

    pipe_stage #(.payload_t(conv_router_pkg::loop_pos_t)) stage_pos (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ctrl_valid),
        .in_data   (ctrl_pos),
        .in_ready  (ctrl_ready),
        .out_valid (pos_valid),
        .out_data  (cur_pos),
        .out_ready (pos_ready)
    );

    // three row lanes, combinational
    for (genvar i = 0; i < conv_router_pkg::LANES; i++) begin : g_lane
        conv_row_lane #(.LANE(i)) row_lane (
            .cfg  (cfg_if.lane),
            .pos  (cur_pos),
            .beat (lane_res[i])
        );
    end

    // beat packing
    assign beat_in.lane      = lane_res;
    assign beat_in.seg_start = cur_pos.seg_start;
    assign beat_in.if_idx    = cur_pos.if_idx;
    assign beat_in.last      = cur_pos.last;

    pipe_stage #(.payload_t(conv_router_pkg::beat_t)) stage_beat (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pos_valid),
        .in_data   (beat_in),
        .in_ready  (pos_ready),
        .out_valid (out_valid),
        .out_data  (beat_out),
        .out_ready (out_ready)
    );

    //////////////////////////////////////////////////
    // output unpacking
    //////////////////////////////////////////////////

    assign out_last      = beat_out.last;
    assign out_seg_start = beat_out.seg_start;
    assign out_if_idx    = beat_out.if_idx;

    for (genvar i = 0; i < conv_router_pkg::LANES; i++) begin : g_out
        assign lane_used[i] = beat_out.lane[i].used;
        assign lane_pad[i]  = beat_out.lane[i].pad;
        assign row_idx[i]   = beat_out.lane[i].row_idx;
        assign buf_idx[i]   = beat_out.lane[i].buf_idx;
        assign buf_adr[i]   = beat_out.lane[i].buf_adr;
    end

endmodule

//--- sim/conv_router_assert.sv
`timescale 1ns/1ps

module conv_router_assert (
    input logic                                                clk,
    input logic                                                reset,
    input logic                                                busy,
    input logic                                                done,
    input logic                                                out_valid,
    input logic                                                out_ready,
    input logic                                                out_last,
    input conv_router_pkg::dim_t                               out_seg_start,
    input conv_router_pkg::dim_t                               out_if_idx,
    input logic [conv_router_pkg::LANES-1:0]                   lane_used,
    input logic [conv_router_pkg::LANES-1:0]                   lane_pad,
    input conv_router_pkg::dim_t [conv_router_pkg::LANES-1:0]  row_idx,
    input conv_router_pkg::dim_t [conv_router_pkg::LANES-1:0]  buf_adr,
    input conv_router_pkg::bank_t [conv_router_pkg::LANES-1:0] buf_idx
);

    // failed protocol checks so far
    int fail_count = 0;

    //////////////////////////////////////////////////
    // output stream protocol
    //////////////////////////////////////////////////

    // stalled beat stays put
    a_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_last)
            && $stable(out_seg_start) && $stable(out_if_idx) && $stable(lane_used)
            && $stable(lane_pad) && $stable(row_idx) && $stable(buf_adr) && $stable(buf_idx))
        else begin
            fail_count++;
            $error("out_valid or beat data changed while out_ready was low");
        end

    // done is one cycle right after the final beat
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |-> !$past(done) && $past(out_valid && out_ready && out_last))
        else begin
            fail_count++;
            $error("done was not a single pulse after the final beat");
        end

    // no beats outside a run
    a_idle: assert property (@(posedge clk) disable iff (reset) !busy |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high while busy was low");
        end

endmodule

bind conv_router conv_router_assert conv_router_assert_i (
    .clk           (clk),
    .reset         (reset),
    .busy          (busy),
    .done          (done),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_last      (out_last),
    .out_seg_start (out_seg_start),
    .out_if_idx    (out_if_idx),
    .lane_used     (lane_used),
    .lane_pad      (lane_pad),
    .row_idx       (row_idx),
    .buf_adr       (buf_adr),
    .buf_idx       (buf_idx)
);

//--- sim/conv_router_tb.sv
`timescale 1ns/1ps

module conv_router_tb;

    // cycles allowed for one layer to reach done
    localparam int RUN_TIMEOUT = 4000;

    logic                                                clk = 1'b0;
    logic                                                reset;
    logic                                                start;
    conv_router_pkg::dim_t                               oy;
    conv_router_pkg::dim_t                               iy;
    logic [1:0]                                          k;
    logic [1:0]                                          s;
    logic [1:0]                                          p;
    logic [2:0]                                          ix_log2;
    logic [2:0]                                          nif_log2;
    logic                                                out_ready;
    logic                                                busy;
    logic                                                done;
    logic                                                out_valid;
    logic                                                out_last;
    conv_router_pkg::dim_t                               out_seg_start;
    conv_router_pkg::dim_t                               out_if_idx;
    logic [conv_router_pkg::LANES-1:0]                   lane_used;
    logic [conv_router_pkg::LANES-1:0]                   lane_pad;
    conv_router_pkg::dim_t [conv_router_pkg::LANES-1:0]  row_idx;
    conv_router_pkg::dim_t [conv_router_pkg::LANES-1:0]  buf_adr;
    conv_router_pkg::bank_t [conv_router_pkg::LANES-1:0] buf_idx;

    // expected beats with the oldest first
    conv_router_pkg::beat_t exp_q[$];
    conv_router_pkg::beat_t got_b;
    conv_router_pkg::beat_t exp_b;

    // running totals written by the compare process
    int          beat_count = 0;
    int          pad_seen = 0;
    int          unused_seen = 0;
    logic        throttle;
    logic [31:0] lfsr;

    conv_router conv_router_i (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic report_and_stop(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // galois step taken once per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] v);
        return v[0] ? ((v >> 1) ^ 32'h8020_0003) : (v >> 1);
    endfunction

    // one lane from the row, padding and bank rules
    function automatic conv_router_pkg::lane_beat_t lane_ref(
        input int lane, input int ys, input int poy_v, input int kr, input int sg, input int c
    );
        conv_router_pkg::lane_beat_t r;
        int y;
        int shift;
        y      = (ys + lane) * int'(s) + kr - int'(p);
        r.used = (lane < poy_v);
        r.pad  = r.used && ((y < 0) || (y >= int'(iy)));
        if (r.used && !r.pad) begin
            // bank by remainder and row in bank by quotient
            shift     = int'(nif_log2) + int'(ix_log2) - conv_router_pkg::PIXELS_LOG2;
            r.row_idx = conv_router_pkg::dim_t'(y);
            r.buf_idx = conv_router_pkg::bank_t'(y % conv_router_pkg::NUM_ROW_BUFS);
            r.buf_adr = conv_router_pkg::dim_t'(
                ((y / conv_router_pkg::NUM_ROW_BUFS) << shift)
                + ((sg / conv_router_pkg::PIXELS_IN_ROW) << nif_log2) + c);
        end else begin
            r.row_idx = conv_router_pkg::NO_ROW;
            r.buf_idx = '0;
            r.buf_adr = conv_router_pkg::NO_ROW;
        end
        return r;
    endfunction

    function automatic conv_router_pkg::beat_t beat_ref(
        input int ys, input int kr, input int sg, input int c
    );
        conv_router_pkg::beat_t b;
        int poy_v;
        // rows left in this tile capped at one per lane
        poy_v = int'(oy) - ys;
        if (poy_v > conv_router_pkg::LANES) begin
            poy_v = conv_router_pkg::LANES;
        end
        for (int l = 0; l < conv_router_pkg::LANES; l++) begin
            b.lane[l] = lane_ref(l, ys, poy_v, kr, sg, c);
        end
        b.seg_start = conv_router_pkg::dim_t'(sg);
        b.if_idx    = conv_router_pkg::dim_t'(c);
        b.last      = 1'b0;
        return b;
    endfunction

    // tile outermost down to channel innermost
    task automatic build_expected();
        conv_router_pkg::beat_t last_b;
        exp_q.delete();
        for (int ys = 0; ys < int'(oy); ys += conv_router_pkg::LANES) begin
            for (int kr = 0; kr < int'(k); kr++) begin
                for (int sg = 0; sg < (1 << ix_log2); sg += conv_router_pkg::PIXELS_IN_ROW) begin
                    for (int c = 0; c < (1 << nif_log2); c++) begin
                        exp_q.push_back(beat_ref(ys, kr, sg, c));
                    end
                end
            end
        end
        last_b      = exp_q.pop_back();
        last_b.last = 1'b1;
        exp_q.push_back(last_b);
    endtask

    //////////////////////////////////////////////////
    // stimulus and compare
    //////////////////////////////////////////////////

    // out_ready takes one random bit per cycle when throttled
    initial begin
        lfsr      = 32'h99d4;
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (throttle) begin
                lfsr      = lfsr_step(lfsr);
                out_ready = lfsr[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // every transfer against the head of the queue
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            assert (exp_q.size() > 0)
                else report_and_stop("DUT issued a beat after the expected sequence ended");
            exp_b            = exp_q.pop_front();
            got_b.seg_start  = out_seg_start;
            got_b.if_idx     = out_if_idx;
            got_b.last       = out_last;
            for (int l = 0; l < conv_router_pkg::LANES; l++) begin
                got_b.lane[l].used    = lane_used[l];
                got_b.lane[l].pad     = lane_pad[l];
                got_b.lane[l].row_idx = row_idx[l];
                got_b.lane[l].buf_idx = buf_idx[l];
                got_b.lane[l].buf_adr = buf_adr[l];
            end
            assert (got_b === exp_b)
                else report_and_stop($sformatf("FAIL @%0t: beat %0d got %h expected %h",
                                               $time, beat_count, got_b, exp_b));
            beat_count++;
            if (|lane_pad) begin
                pad_seen++;
            end
            if (lane_used != '1) begin
                unused_seen++;
            end
        end
    end

    task automatic run_layer(
        input int t_oy, input int t_iy, input int t_k, input int t_s, input int t_p,
        input int t_ix, input int t_nif, input logic t_throttle, input logic poke,
        input logic want_pad, input logic want_unused
    );
        int n;
        int exp_count;
        int pad0;
        int unused0;
        @(negedge clk);
        oy       = conv_router_pkg::dim_t'(t_oy);
        iy       = conv_router_pkg::dim_t'(t_iy);
        k        = 2'(t_k);
        s        = 2'(t_s);
        p        = 2'(t_p);
        ix_log2  = 3'(t_ix);
        nif_log2 = 3'(t_nif);
        throttle <= t_throttle;
        build_expected();
        // tiles x kernel rows x segments x channels
        exp_count = ((t_oy + 2) / 3) * t_k * (1 << (t_ix - 5)) * (1 << t_nif);
        assert (exp_q.size() == exp_count)
            else report_and_stop("expected sequence length disagrees with the loop counts");
        pad0    = pad_seen;
        unused0 = unused_seen;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        assert (busy) else report_and_stop("busy did not rise the cycle after start");
        n = 0;
        while (!done && n < RUN_TIMEOUT) begin
            @(negedge clk);
            n++;
            // second start in the middle of the run
            if (poke) begin
                start = (n == 6);
                if (n == 6) begin
                    assert (busy) else report_and_stop("run ended before the mid-run start");
                end
            end
        end
        start = 1'b0;
        assert (done) else report_and_stop("timed out waiting for done");
        assert (!busy) else report_and_stop("busy still high in the done cycle");
        assert (exp_q.size() == 0)
            else report_and_stop("done came before every expected beat was seen");
        // no stall means three cycles to the first beat and then one beat per cycle
        if (!t_throttle) begin
            assert (n == exp_count + 2)
                else report_and_stop($sformatf("FAIL @%0t: done after %0d cycles, expected %0d",
                                               $time, n, exp_count + 2));
        end
        if (want_pad) begin
            assert (pad_seen > pad0) else report_and_stop("no padded lane seen in this run");
        end
        if (want_unused) begin
            assert (unused_seen > unused0) else report_and_stop("no unused lane seen in this run");
        end
    endtask

    initial begin
        reset    = 1'b1;
        start    = 1'b0;
        oy       = '0;
        iy       = '0;
        k        = '0;
        s        = '0;
        p        = '0;
        ix_log2  = '0;
        nif_log2 = '0;
        throttle = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        // idle after reset until a start
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            assert (!busy && !done && !out_valid)
                else report_and_stop("busy, done or out_valid high before any start");
        end
        // stride 1 with pad 1 pads the border lanes
        run_layer(9, 9, 3, 1, 1, 6, 1, 1'b0, 1'b0, 1'b1, 1'b0);
        // stride 2 with a partial last tile
        run_layer(7, 16, 2, 2, 0, 5, 2, 1'b0, 1'b0, 1'b0, 1'b1);
        // random back-pressure
        run_layer(8, 8, 3, 1, 1, 7, 0, 1'b1, 1'b0, 1'b1, 1'b0);
        // start ignored mid-run and then a different layer
        run_layer(5, 11, 3, 2, 2, 5, 3, 1'b1, 1'b1, 1'b1, 1'b1);
        run_layer(4, 4, 1, 1, 0, 6, 0, 1'b0, 1'b0, 1'b0, 1'b1);
        // bound protocol checks
        if (conv_router_i.conv_router_assert_i.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_and_stop("a bound protocol assertion failed during the run");
        end
    end

endmodule

//--- build.f
source/conv_router_pkg.sv
source/layer_cfg_if.sv
source/pipe_stage.sv
source/conv_row_lane.sv
source/conv_loop_ctrl.sv
source/conv_router.sv
sim/conv_router_assert.sv
sim/conv_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the conv_router testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_router_tb -Mdir "$OBJ_DIR" -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

"./$OBJ_DIR/Vconv_router_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# result comes from the log
if grep -qx ">>> PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
